//--- design/rv_soc_consts.svh
`ifndef RV_SOC_CONSTS_SVH
`define RV_SOC_CONSTS_SVH

// Data path width in bits
`define RV_XLEN 32

// Data SRAM size in words
`define RV_DMEM_DEPTH 1024

// Address bit that moves an access out to the I/O port
`define RV_IO_SEL_BIT 31

`endif

//--- design/rv_soc_pkg.sv
package rv_soc_pkg;

  // Who issued a request; also used to index the response valids
  typedef enum logic {
    REQ_CORE   = 1'b0,
    REQ_LOADER = 1'b1
  } req_id_t;

  // Target of a decoded address
  typedef enum logic {
    REGION_SRAM = 1'b0,
    REGION_IO   = 1'b1
  } region_t;

endpackage

//--- design/rv_bus_pkg.sv
`include "rv_soc_consts.svh"

package rv_bus_pkg;

  import rv_soc_pkg::*;

  // One data bus request, as driven by a requester
  typedef struct packed {
    logic                     we;
    logic [`RV_XLEN-1:0]      addr;
    logic [`RV_XLEN-1:0]      wdata;
    logic [(`RV_XLEN/8)-1:0]  wstrb;
  } bus_req_t;

  // Read response, tagged with the requester it belongs to
  typedef struct packed {
    logic [`RV_XLEN-1:0] rdata;
    req_id_t             id;
  } bus_rsp_t;

endpackage

//--- design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
  import rv_soc_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  input  logic     [1:0] req_valid,
  input  payload_t req [2],
  output logic     [1:0] req_ready,

  output logic     out_valid,
  output payload_t out_req,
  output req_id_t  out_id,
  input  logic     out_ready
);

  req_id_t last_grant;
  req_id_t grant;
  logic    locked;
  req_id_t locked_id;

  // Pick a requester, sticking with the current one while stalled
  always_comb begin
    if (locked) begin
      grant = locked_id;
    end else if (req_valid[REQ_CORE] && req_valid[REQ_LOADER]) begin
      grant = (last_grant == REQ_CORE) ? REQ_LOADER : REQ_CORE;
    end else if (req_valid[REQ_LOADER]) begin
      grant = REQ_LOADER;
    end else begin
      grant = REQ_CORE;
    end
  end

  assign out_valid = req_valid[grant];
  assign out_req   = req[grant];
  assign out_id    = grant;

  // No added cycle, ready comes straight from downstream
  assign req_ready[REQ_CORE]   = out_ready && (grant == REQ_CORE);
  assign req_ready[REQ_LOADER] = out_ready && (grant == REQ_LOADER);

  always_ff @(posedge clk) begin
    if (rst) begin
      // Loader counts as last served so the core wins first
      last_grant <= REQ_LOADER;
      locked     <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        last_grant <= grant;
      end
      locked <= out_valid && !out_ready;
    end
  end

  always_ff @(posedge clk) begin
    locked_id <= grant;
  end

endmodule

//--- design/data_sram.sv
`timescale 1ns/1ps

`include "rv_soc_consts.svh"

module data_sram #(
  parameter int AW = $clog2(`RV_DMEM_DEPTH)
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     en,
  input  logic                     we,
  input  logic [AW-1:0]            addr,
  input  logic [`RV_XLEN-1:0]      wdata,
  input  logic [(`RV_XLEN/8)-1:0]  wstrb,

  output logic [`RV_XLEN-1:0]      rdata,
  output logic                     rdata_valid
);

  logic [`RV_XLEN-1:0] mem [`RV_DMEM_DEPTH];

  // Byte lanes are written independently
  always_ff @(posedge clk) begin
    if (en && we) begin
      for (int b = 0; b < `RV_XLEN / 8; b++) begin
        if (wstrb[b]) begin
          mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (en && !we) begin
      rdata <= mem[addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rdata_valid <= 1'b0;
    end else begin
      rdata_valid <= en && !we;
    end
  end

endmodule

//--- design/bus_router.sv
`timescale 1ns/1ps

`include "rv_soc_consts.svh"

module bus_router
  import rv_soc_pkg::*;
  import rv_bus_pkg::*;
#(
  parameter int AW = $clog2(`RV_DMEM_DEPTH)
) (
  input  logic                     clk,
  input  logic                     rst,

  // From the arbiter
  input  logic                     in_valid,
  input  bus_req_t                 in_req,
  input  req_id_t                  in_id,
  output logic                     in_ready,

  // Data SRAM
  output logic                     sram_en,
  output logic                     sram_we,
  output logic [AW-1:0]            sram_addr,
  output logic [`RV_XLEN-1:0]      sram_wdata,
  output logic [(`RV_XLEN/8)-1:0]  sram_wstrb,
  input  logic [`RV_XLEN-1:0]      sram_rdata,
  input  logic                     sram_rdata_valid,

  // External I/O
  output logic                     io_req_valid,
  output bus_req_t                 io_req,
  input  logic                     io_req_ready,
  input  logic                     io_rsp_valid,
  input  logic [`RV_XLEN-1:0]      io_rdata,

  // Back to the requesters
  output logic [1:0]               rsp_valid,
  output bus_rsp_t                 rsp
);

  region_t region;
  logic    active;
  logic    can_accept;
  logic    accept;
  logic    rsp_done;

  // Outstanding read tracking, one deep
  logic    pending;
  logic    pending_io;
  req_id_t pending_id;

  assign region = in_req.addr[`RV_IO_SEL_BIT] ? REGION_IO : REGION_SRAM;

  // Nothing is taken while a read is in flight
  assign can_accept = active && !pending;
  assign in_ready   = can_accept && ((region == REGION_SRAM) || io_req_ready);
  assign accept     = in_valid && in_ready;

  assign sram_en    = in_valid && can_accept && (region == REGION_SRAM);
  assign sram_we    = in_req.we;
  assign sram_addr  = in_req.addr[AW+1:2];
  assign sram_wdata = in_req.wdata;
  assign sram_wstrb = in_req.wstrb;

  assign io_req_valid = in_valid && can_accept && (region == REGION_IO);
  assign io_req       = in_req;

  // Read data comes from whichever side the pending read went to
  assign rsp_done  = pending && (pending_io ? io_rsp_valid : sram_rdata_valid);
  assign rsp.rdata = pending_io ? io_rdata : sram_rdata;
  assign rsp.id    = pending_id;

  assign rsp_valid[REQ_CORE]   = rsp_done && (pending_id == REQ_CORE);
  assign rsp_valid[REQ_LOADER] = rsp_done && (pending_id == REQ_LOADER);

  always_ff @(posedge clk) begin
    if (rst) begin
      active     <= 1'b0;
      pending    <= 1'b0;
      pending_io <= 1'b0;
    end else begin
      // Hold off requests for one cycle after reset
      active <= 1'b1;
      if (accept && !in_req.we) begin
        pending    <= 1'b1;
        pending_io <= (region == REGION_IO);
      end else if (rsp_done) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !in_req.we) begin
      pending_id <= in_id;
    end
  end

endmodule

//--- design/rv_mem_subsys.sv
`timescale 1ns/1ps

`include "rv_soc_consts.svh"

module rv_mem_subsys
  import rv_soc_pkg::*;
  import rv_bus_pkg::*;
(
  input  logic                clk,
  input  logic                rst,

  // Core load/store port
  input  logic                core_valid,
  input  bus_req_t            core_req,
  output logic                core_ready,

  // Loader/debug port
  input  logic                loader_valid,
  input  bus_req_t            loader_req,
  output logic                loader_ready,

  // Shared response, one valid per requester
  output logic                core_rsp_valid,
  output logic                loader_rsp_valid,
  output bus_rsp_t            rsp,

  // Memory-mapped I/O
  output logic                io_req_valid,
  output bus_req_t            io_req,
  input  logic                io_req_ready,
  input  logic                io_rsp_valid,
  input  logic [`RV_XLEN-1:0] io_rdata
);

  localparam int DMEM_AW = $clog2(`RV_DMEM_DEPTH);

  bus_req_t                    arb_in [2];
  logic     [1:0]              arb_ready;
  logic                        arb_valid;
  bus_req_t                    arb_req;
  req_id_t                     arb_id;
  logic                        rtr_ready;
  logic     [1:0]              rtr_rsp_valid;

  logic                        sram_en;
  logic                        sram_we;
  logic     [DMEM_AW-1:0]      sram_addr;
  logic     [`RV_XLEN-1:0]     sram_wdata;
  logic     [(`RV_XLEN/8)-1:0] sram_wstrb;
  logic     [`RV_XLEN-1:0]     sram_rdata;
  logic                        sram_rdata_valid;

  assign arb_in[REQ_CORE]   = core_req;
  assign arb_in[REQ_LOADER] = loader_req;

  assign core_ready       = arb_ready[REQ_CORE];
  assign loader_ready     = arb_ready[REQ_LOADER];
  assign core_rsp_valid   = rtr_rsp_valid[REQ_CORE];
  assign loader_rsp_valid = rtr_rsp_valid[REQ_LOADER];

  mem_arbiter #(
    .payload_t(bus_req_t)
  ) u_mem_arbiter (
    .clk      (clk),
    .rst      (rst),
    .req_valid({loader_valid, core_valid}),
    .req      (arb_in),
    .req_ready(arb_ready),
    .out_valid(arb_valid),
    .out_req  (arb_req),
    .out_id   (arb_id),
    .out_ready(rtr_ready)
  );

  bus_router #(
    .AW(DMEM_AW)
  ) u_bus_router (
    .clk             (clk),
    .rst             (rst),
    .in_valid        (arb_valid),
    .in_req          (arb_req),
    .in_id           (arb_id),
    .in_ready        (rtr_ready),
    .sram_en         (sram_en),
    .sram_we         (sram_we),
    .sram_addr       (sram_addr),
    .sram_wdata      (sram_wdata),
    .sram_wstrb      (sram_wstrb),
    .sram_rdata      (sram_rdata),
    .sram_rdata_valid(sram_rdata_valid),
    .io_req_valid    (io_req_valid),
    .io_req          (io_req),
    .io_req_ready    (io_req_ready),
    .io_rsp_valid    (io_rsp_valid),
    .io_rdata        (io_rdata),
    .rsp_valid       (rtr_rsp_valid),
    .rsp             (rsp)
  );

  data_sram #(
    .AW(DMEM_AW)
  ) u_data_sram (
    .clk        (clk),
    .rst        (rst),
    .en         (sram_en),
    .we         (sram_we),
    .addr       (sram_addr),
    .wdata      (sram_wdata),
    .wstrb      (sram_wstrb),
    .rdata      (sram_rdata),
    .rdata_valid(sram_rdata_valid)
  );

endmodule

//--- verification/rv_mem_subsys_tb.sv
`timescale 1ns/1ps

`include "rv_soc_consts.svh"

module rv_mem_subsys_tb
  import rv_soc_pkg::*;
  import rv_bus_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int RST_CYCLES      = 16;
  localparam int CYCLES_PER_CASE = 20;
  localparam int MAX_CASES       = 64;
  localparam int WORDS_PER_CASE  = 6;
  localparam int DMEM_AW         = $clog2(`RV_DMEM_DEPTH);
  localparam logic [31:0] IO_XOR   = 32'h5a5a_5a5a;
  localparam logic [31:0] END_MARK = 32'h0000_00ff;
  localparam logic [31:0] SEED     = 32'ha930_794e;

  logic                clk;
  logic                rst;
  logic [1:0]          valid;
  bus_req_t            req_in [2];
  logic [1:0]          ready;
  logic [1:0]          rsp_vld;
  bus_rsp_t            rsp;
  logic                io_req_valid;
  bus_req_t            io_req;
  logic                io_req_ready;
  logic                io_rsp_valid;
  logic [`RV_XLEN-1:0] io_rdata;

  logic [31:0] case_words [MAX_CASES*WORDS_PER_CASE];
  int          n_cases;
  bit          loaded;
  logic [31:0] ref_mem [`RV_DMEM_DEPTH];
  req_id_t     last_grant_model;

  rv_mem_subsys u_rv_mem_subsys (
    .clk             (clk),
    .rst             (rst),
    .core_valid      (valid[REQ_CORE]),
    .core_req        (req_in[REQ_CORE]),
    .core_ready      (ready[REQ_CORE]),
    .loader_valid    (valid[REQ_LOADER]),
    .loader_req      (req_in[REQ_LOADER]),
    .loader_ready    (ready[REQ_LOADER]),
    .core_rsp_valid  (rsp_vld[REQ_CORE]),
    .loader_rsp_valid(rsp_vld[REQ_LOADER]),
    .rsp             (rsp),
    .io_req_valid    (io_req_valid),
    .io_req          (io_req),
    .io_req_ready    (io_req_ready),
    .io_rsp_valid    (io_rsp_valid),
    .io_rdata        (io_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] got);
    abort_run($sformatf("CHECK FAILED at %0t: %s expected %0h, got %0h",
                        $time, name, exp, got));
  endtask

  function automatic string ready_name(input req_id_t id);
    return (id == REQ_CORE) ? "core_ready" : "loader_ready";
  endfunction

  function automatic string rsp_name(input req_id_t id);
    return (id == REQ_CORE) ? "core_rsp_valid" : "loader_rsp_valid";
  endfunction

  // Reference byte merge for strobed writes
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic check_idle();
    assert (ready == 2'b00) else report_mismatch("ready", 2'b00, ready);
    assert (rsp_vld == 2'b00) else report_mismatch("rsp_valid", 2'b00, rsp_vld);
    assert (io_req_valid == 1'b0) else report_mismatch("io_req_valid", 1'b0, io_req_valid);
  endtask

  task automatic load_case(input int idx, output req_id_t id, output bus_req_t r,
                           output logic [31:0] exp);
    logic [31:0] who;
    logic [31:0] op;
    who = case_words[idx*WORDS_PER_CASE];
    op  = case_words[idx*WORDS_PER_CASE + 1];
    if (who !== 32'd0 && who !== 32'd1) begin
      abort_run($sformatf("Case %0d has an unknown requester code", idx));
    end
    id      = req_id_t'(who[0]);
    r.we    = op[0];
    r.addr  = case_words[idx*WORDS_PER_CASE + 2];
    r.wdata = case_words[idx*WORDS_PER_CASE + 3];
    r.wstrb = case_words[idx*WORDS_PER_CASE + 4][3:0];
    exp     = case_words[idx*WORDS_PER_CASE + 5];
  endtask

  // Handshake of one requester while the other one may also be waiting
  task automatic wait_accept(input req_id_t id, input bus_req_t r, input bit other_waiting);
    req_id_t            other;
    region_t            region;
    logic [DMEM_AW-1:0] word;
    other  = (id == REQ_CORE) ? REQ_LOADER : REQ_CORE;
    region = r.addr[`RV_IO_SEL_BIT] ? REGION_IO : REGION_SRAM;
    word   = r.addr[DMEM_AW+1:2];
    do begin
      @(negedge clk);
      if (other_waiting) begin
        assert (ready[other] !== 1'b1) else report_mismatch(ready_name(other), 1'b0, ready[other]);
      end
    end while (ready[id] !== 1'b1);
    assert (rsp_vld == 2'b00) else report_mismatch("rsp_valid", 2'b00, rsp_vld);
    if (region == REGION_IO) begin
      assert (io_req_valid === 1'b1) else report_mismatch("io_req_valid", 1'b1, io_req_valid);
      assert (io_req === r) else report_mismatch("io_req", r, io_req);
    end else begin
      assert (io_req_valid === 1'b0) else report_mismatch("io_req_valid", 1'b0, io_req_valid);
    end
    @(posedge clk);
    valid[id] <= 1'b0;
    last_grant_model = id;
    if (r.we && region == REGION_SRAM) begin
      ref_mem[word] = merge_bytes(ref_mem[word], r.wdata, r.wstrb);
    end
  endtask

  task automatic wait_response(input req_id_t id, input bus_req_t r, input logic [31:0] exp);
    req_id_t     other;
    logic [31:0] predicted;
    other = (id == REQ_CORE) ? REQ_LOADER : REQ_CORE;
    if (r.addr[`RV_IO_SEL_BIT]) begin
      predicted = r.addr ^ IO_XOR;
    end else begin
      predicted = ref_mem[r.addr[DMEM_AW+1:2]];
    end
    if (predicted !== exp) begin
      abort_run($sformatf("Case file expects %h at address %h but the model holds %h",
                          exp, r.addr, predicted));
    end
    // SRAM answers in the very next cycle and I/O whenever it is ready
    if (r.addr[`RV_IO_SEL_BIT]) begin
      do @(negedge clk); while (rsp_vld == 2'b00);
    end else begin
      @(negedge clk);
    end
    assert (rsp_vld[id] === 1'b1) else report_mismatch(rsp_name(id), 1'b1, rsp_vld[id]);
    assert (rsp_vld[other] === 1'b0) else report_mismatch(rsp_name(other), 1'b0, rsp_vld[other]);
    assert (rsp.id === id) else report_mismatch("rsp.id", id, rsp.id);
    assert (rsp.rdata === exp) else report_mismatch("rsp.rdata", exp, rsp.rdata);
  endtask

  task automatic run_single(input int idx);
    req_id_t     id;
    bus_req_t    r;
    logic [31:0] exp;
    load_case(idx, id, r, exp);
    @(posedge clk);
    valid[id]  <= 1'b1;
    req_in[id] <= r;
    wait_accept(id, r, 1'b0);
    if (!r.we) begin
      wait_response(id, r, exp);
    end
  endtask

  task automatic run_pair(input int idx);
    req_id_t     id_a;
    req_id_t     id_b;
    req_id_t     first;
    bus_req_t    r_a;
    bus_req_t    r_b;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    if (idx + 1 >= n_cases) begin
      abort_run($sformatf("Case %0d is paired with a case that does not exist", idx));
    end
    load_case(idx, id_a, r_a, exp_a);
    load_case(idx + 1, id_b, r_b, exp_b);
    if (id_a == id_b) begin
      abort_run($sformatf("Cases %0d and %0d pair the same requester", idx, idx + 1));
    end
    // The requester not served last goes first
    first = (last_grant_model == REQ_CORE) ? REQ_LOADER : REQ_CORE;
    @(posedge clk);
    valid        <= 2'b11;
    req_in[id_a] <= r_a;
    req_in[id_b] <= r_b;
    if (first == id_a) begin
      wait_accept(id_a, r_a, 1'b1);
      if (!r_a.we) wait_response(id_a, r_a, exp_a);
      wait_accept(id_b, r_b, 1'b0);
      if (!r_b.we) wait_response(id_b, r_b, exp_b);
    end else begin
      wait_accept(id_b, r_b, 1'b1);
      if (!r_b.we) wait_response(id_b, r_b, exp_b);
      wait_accept(id_a, r_a, 1'b0);
      if (!r_a.we) wait_response(id_a, r_a, exp_a);
    end
  endtask

  // I/O responder with random accept and response delays
  initial begin
    int unsigned delay;
    bus_req_t    seen;
    io_req_ready = 1'b0;
    io_rsp_valid = 1'b0;
    io_rdata     = '0;
    void'($urandom(SEED));
    forever begin
      @(negedge clk);
      if (io_req_valid === 1'b1) begin
        delay = $urandom % 4;
        repeat (delay) @(negedge clk);
        @(posedge clk);
        io_req_ready <= 1'b1;
        @(negedge clk);
        seen = io_req;
        @(posedge clk);
        io_req_ready <= 1'b0;
        if (!seen.we) begin
          delay = $urandom % 4;
          repeat (delay) @(posedge clk);
          io_rsp_valid <= 1'b1;
          io_rdata     <= seen.addr ^ IO_XOR;
          @(posedge clk);
          io_rsp_valid <= 1'b0;
        end
      end
    end
  end

  initial begin
    time limit;
    wait (loaded);
    limit = (n_cases * CYCLES_PER_CASE + RST_CYCLES) * CLK_PERIOD;
    #(limit);
    abort_run("Watchdog expired before all cases completed");
  end

  initial begin
    int idx;
    rst              = 1'b1;
    valid            = 2'b00;
    req_in[0]        = '0;
    req_in[1]        = '0;
    // Core I/O read held through reset, which must not reach the bus
    valid[REQ_CORE]       = 1'b1;
    req_in[REQ_CORE].addr = 32'h8000_0000;
    last_grant_model = REQ_LOADER;
    $readmemh("verification/mem_cases.txt", case_words);
    n_cases = 0;
    while (n_cases < MAX_CASES && case_words[n_cases*WORDS_PER_CASE] !== END_MARK) begin
      n_cases++;
    end
    loaded = 1'b1;

    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_idle();
    @(posedge clk);
    rst <= 1'b0;
    // Ports stay closed for one more cycle
    @(negedge clk);
    check_idle();
    @(posedge clk);
    valid <= 2'b00;

    idx = 0;
    while (idx < n_cases) begin
      if (case_words[idx*WORDS_PER_CASE + 1][1]) begin
        run_pair(idx);
        idx += 2;
      end else begin
        run_single(idx);
        idx += 1;
      end
    end
    repeat (2) @(posedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- verification/mem_cases.txt
// who op addr wdata strb expect  (who 0 core, 1 loader; op bit0 write, bit1 issue with next line)
// expect is the read data and is ignored for writes; who ff ends the list
00000000 00000003 00000010 11223344 0000000f 00000000
00000001 00000001 00000020 a5a5c3c3 0000000f 00000000
00000000 00000000 00000010 00000000 00000000 11223344
00000001 00000000 00000020 00000000 00000000 a5a5c3c3
00000000 00000001 00000030 deadbeef 0000000f 00000000
00000000 00000001 00000030 00005500 00000002 00000000
00000001 00000001 00000030 99000000 00000008 00000000
00000000 00000000 00000030 00000000 00000000 99ad55ef
00000001 00000001 00000ffc 0badf00d 0000000f 00000000
00000001 00000001 00000ffc 12345678 00000005 00000000
00000000 00000000 00000ffc 00000000 00000000 0b34f078
00000000 00000001 80000010 cafef00d 00000003 00000000
00000001 00000000 00000010 00000000 00000000 11223344
00000000 00000000 80000040 00000000 00000000 da5a5a1a
00000001 00000000 8000abc4 00000000 00000000 da5af19e
00000000 00000002 00000030 00000000 00000000 99ad55ef
00000001 00000000 00000020 00000000 00000000 a5a5c3c3
00000000 00000001 00000040 01020304 0000000f 00000000
00000000 00000002 80000100 00000000 00000000 da5a5b5a
00000001 00000000 00000040 00000000 00000000 01020304
00000001 00000003 80000200 55aa55aa 0000000f 00000000
00000000 00000001 00000044 a0b0c0d0 0000000f 00000000
00000001 00000000 00000044 00000000 00000000 a0b0c0d0
00000000 00000002 80000010 00000000 00000000 da5a5a4a
00000001 00000000 80000020 00000000 00000000 da5a5a7a
00000000 00000000 00000020 00000000 00000000 a5a5c3c3
000000ff 00000000 00000000 00000000 00000000 00000000

//--- files.f
+incdir+design
design/rv_soc_pkg.sv
design/rv_bus_pkg.sv
design/mem_arbiter.sv
design/data_sram.sv
design/bus_router.sv
design/rv_mem_subsys.sv
verification/rv_mem_subsys_tb.sv

//--- Bender.yml
package:
  name: rv_mem_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/rv_soc_pkg.sv
      - design/rv_bus_pkg.sv
      - design/mem_arbiter.sv
      - design/data_sram.sv
      - design/bus_router.sv
      - design/rv_mem_subsys.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/rv_mem_subsys_tb.sv
